// ==== hdl/core_macros.svh ====
// ***************************************
// core-wide sizes and constants
// shared by every rtl file of the core
// ***************************************
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data and address width
`define XLEN 32

// register file depth, x0 included
`define NUM_REGS 32

`define RESET_PC 32'h0000_0000  // first fetch after reset

// x17 value that turns ecall into a halt
`define HALT_CODE 10

`endif

// ==== hdl/isa_pkg.sv ====
// ***************************************
// rv32i subset encodings
// opcodes, funct fields and the
// instruction formats as one union
// ***************************************
package isa_pkg;

  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_SYSTEM = 7'b1110011   // ecall only
  } opcode_e;

  // funct3 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;  // add, sub, addi
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_WORD    = 3'b010;  // lw / sw

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  // branch offset is scattered, bit 0 implied zero
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one word, five views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    j_fmt_t j;
  } inst_u;

endpackage

// ==== hdl/pipe_pkg.sv ====
// ***************************************
// pipeline types of the core
// alu ops, forward selects, control bundle
// ***************************************
package pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT   // signed compare
  } alu_op_e;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_REG,  // value read in decode
    FWD_ALU,  // instruction now in ex/result
    FWD_WB    // instruction now writing back
  } fwd_sel_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src;    // imm as operand b
    alu_op_e alu_op;
    logic    branch;
    logic    branch_ne;  // bne when set, else beq
    logic    is_jal;
    logic    is_jalr;
    logic    pc_to_reg;  // rd gets pc+4
    logic    is_halt;
  } ctrl_t;

endpackage

// ==== hdl/pipe_ifs.sv ====
// ***************************************
// stage to stage interfaces of the core
// id/ex bundle, ex/result bundle and
// the register writeback port
// ***************************************
`include "core_macros.svh"

interface id_ex_if import pipe_pkg::*; ();
  logic             valid;
  ctrl_t            ctrl;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pc_plus_4;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] imm;
  logic [4:0]       rd;

  modport source (output valid, ctrl, pc, pc_plus_4, rs1, rs2, rs1_data, rs2_data, imm, rd);
  modport sink (input valid, ctrl, pc, pc_plus_4, rs1, rs2, rs1_data, rs2_data, imm, rd);
endinterface

interface ex_res_if import pipe_pkg::*; ();
  logic             valid;
  ctrl_t            ctrl;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] store_data;
  logic [`XLEN-1:0] link;
  logic [4:0]       rd;
  logic [`XLEN-1:0] fwd_value;  // result value as seen by forwarding
  logic             busy;       // load data not there yet

  modport source (output valid, ctrl, alu_out, store_data, link, rd, input fwd_value, busy);
  modport sink (input valid, ctrl, alu_out, store_data, link, rd, output fwd_value, busy);
endinterface

interface wb_if ();
  logic             we;
  logic [4:0]       rd;
  logic [`XLEN-1:0] data;

  modport source (output we, rd, data);
  modport sink (input we, rd, data);
endinterface

// ==== hdl/decode_stage.sv ====
// ***************************************
// fetch and decode stage
// pc, if/id register, decoder, immediates,
// register file, load-use stall, halt
// ***************************************
`include "core_macros.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  input  logic             redirect_valid,
  input  logic [`XLEN-1:0] redirect_target,
  input  logic             stall_all,
  input  logic             halted,
  id_ex_if.source          id_ex,
  wb_if.sink               wb,
  input  logic [`XLEN-1:0] fwd_alu
);
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] if_inst;
  logic [`XLEN-1:0] if_pc;
  logic             if_valid;
  logic [`XLEN-1:0] regs [`NUM_REGS];
  inst_u            ir;
  opcode_e          opc;
  logic             is_ecall;
  logic             use_rs1;
  logic             use_rs2;
  logic [4:0]       rs1_sel;
  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;
  logic [`XLEN-1:0] x17_val;
  logic [`XLEN-1:0] imm;
  ctrl_t            dec_ctrl;
  logic             x17_in_res;     // ex/result is writing x17
  logic             halt_pending;   // halting ecall still in flight
  logic             freeze;
  logic             load_use_stall;
  logic             issue;

  // register read with same-cycle writeback bypass
  function automatic logic [`XLEN-1:0] rf_read(input logic [4:0] a);
    if (a == 5'd0)
      return '0;  // x0 always zero
    if (wb.we && wb.rd == a)
      return wb.data;
    return regs[a];
  endfunction

  function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic sub);
    case (f3)
      F3_SLT:  return ALU_SLT;
      F3_OR:   return ALU_OR;
      F3_AND:  return ALU_AND;
      default: return sub ? ALU_SUB : ALU_ADD;
    endcase
  endfunction

  assign imem_addr = pc;
  assign ir        = if_inst;
  assign opc       = ir.r.opcode;
  assign is_ecall  = (opc == OP_SYSTEM);
  assign rs1_sel   = is_ecall ? 5'd17 : ir.r.rs1;  // ecall looks at a7
  assign use_rs1   = (opc != OP_JAL);
  assign use_rs2   = (opc == OP_R) || (opc == OP_STORE) || (opc == OP_BRANCH);

  assign rs1_val = rf_read(rs1_sel);
  assign rs2_val = rf_read(ir.r.rs2);
  assign x17_val = x17_in_res ? fwd_alu : rs1_val;  // newest copy of x17

  // one bubble behind a load, and ecall waits for an x17 writer in execute
  assign load_use_stall = if_valid && id_ex.valid && id_ex.rd != 5'd0 &&
    ((id_ex.ctrl.mem_read &&
      ((use_rs1 && id_ex.rd == rs1_sel) || (use_rs2 && id_ex.rd == ir.r.rs2))) ||
     (is_ecall && id_ex.ctrl.reg_write && id_ex.rd == rs1_sel));

  assign freeze = halt_pending || halted;
  assign issue  = if_valid && !load_use_stall && !redirect_valid && !freeze;

  always_comb begin
    dec_ctrl = '0;
    case (opc)
      OP_R: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.alu_op    = f3_to_alu(ir.r.funct3, ir.r.funct7 == F7_SUB);
      end
      OP_IMM: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.alu_src   = 1'b1;
        dec_ctrl.alu_op    = f3_to_alu(ir.i.funct3, 1'b0);  // no subi
      end
      OP_LOAD: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.mem_read  = 1'b1;
        dec_ctrl.alu_src   = 1'b1;
      end
      OP_STORE: begin
        dec_ctrl.mem_write = 1'b1;
        dec_ctrl.alu_src   = 1'b1;
      end
      OP_BRANCH: begin
        dec_ctrl.branch    = 1'b1;
        dec_ctrl.branch_ne = (ir.b.funct3 == F3_BNE);
      end
      OP_JAL: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.is_jal    = 1'b1;
        dec_ctrl.pc_to_reg = 1'b1;
      end
      OP_JALR: begin
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.is_jalr   = 1'b1;
        dec_ctrl.pc_to_reg = 1'b1;
        dec_ctrl.alu_src   = 1'b1;  // target = rs1 + imm
      end
      OP_SYSTEM: dec_ctrl.is_halt = (x17_val == `HALT_CODE);  // else a nop
      default: ;
    endcase
  end

  always_comb begin
    case (opc)
      OP_STORE:  imm = {{(`XLEN-12){ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
      OP_BRANCH: imm = {{(`XLEN-13){ir.b.imm12}}, ir.b.imm12, ir.b.imm11,
                        ir.b.imm10_5, ir.b.imm4_1, 1'b0};
      OP_JAL:    imm = {{(`XLEN-21){ir.j.imm20}}, ir.j.imm20, ir.j.imm19_12,
                        ir.j.imm11, ir.j.imm10_1, 1'b0};
      default:   imm = {{(`XLEN-12){ir.i.imm[11]}}, ir.i.imm};
    endcase
  end

  always_ff @(posedge clk) begin
    if (wb.we && wb.rd != 5'd0)
      regs[wb.rd] <= wb.data;
  end

  // pc and if/id
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= `RESET_PC;
      if_valid <= 1'b0;
    end else if (!stall_all) begin
      if (redirect_valid) begin
        pc       <= redirect_target;
        if_valid <= 1'b0;  // kill the fetch in flight
      end else if (freeze) begin
        if_valid <= 1'b0;  // fetch stops here
      end else if (!load_use_stall) begin
        pc       <= pc + `XLEN'd4;
        if_valid <= 1'b1;
        if_inst  <= imem_data;
        if_pc    <= pc;
      end
    end
  end

  // id/ex control
  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.valid  <= 1'b0;
      id_ex.ctrl   <= '0;
      x17_in_res   <= 1'b0;
      halt_pending <= 1'b0;
    end else if (!stall_all) begin
      id_ex.valid <= issue;  // bubble on stall, redirect or halt
      id_ex.ctrl  <= dec_ctrl;
      x17_in_res  <= id_ex.valid && id_ex.ctrl.reg_write && id_ex.rd == 5'd17;
      if (issue && dec_ctrl.is_halt)
        halt_pending <= 1'b1;
      else if (halted)
        halt_pending <= 1'b0;  // halted takes over
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_all) begin
      id_ex.pc        <= if_pc;
      id_ex.pc_plus_4 <= if_pc + `XLEN'd4;
      id_ex.rs1       <= rs1_sel;
      id_ex.rs2       <= ir.r.rs2;
      id_ex.rs1_data  <= rs1_val;
      id_ex.rs2_data  <= rs2_val;
      id_ex.imm       <= imm;
      id_ex.rd        <= ir.r.rd;
    end
  end

endmodule

// ==== hdl/execute_stage.sv ====
// ***************************************
// execute stage
// operand forwarding, alu, branch and
// jump resolution, ex/result register
// ***************************************
`include "core_macros.svh"

module execute_stage import pipe_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  id_ex_if.sink            id_ex,
  ex_res_if.source         ex_res,
  wb_if.sink               wb,
  input  logic             stall_all,
  output logic             redirect_valid,
  output logic [`XLEN-1:0] redirect_target
);
  fwd_sel_e         sel_a;
  fwd_sel_e         sel_b;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b_reg;  // rs2 after forwarding, also store data
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_out;
  logic             taken;

  function automatic fwd_sel_e pick_src(input logic [4:0] r);
    if (r == 5'd0)
      return FWD_REG;
    if (ex_res.valid && ex_res.ctrl.reg_write && !ex_res.busy && ex_res.rd == r)
      return FWD_ALU;  // youngest producer wins
    if (wb.we && wb.rd == r)
      return FWD_WB;
    return FWD_REG;
  endfunction

  function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e s,
                                               input logic [`XLEN-1:0] reg_val);
    case (s)
      FWD_ALU: return ex_res.fwd_value;  // link for jumps
      FWD_WB:  return wb.data;
      default: return reg_val;
    endcase
  endfunction

  assign sel_a    = pick_src(id_ex.rs1);
  assign sel_b    = pick_src(id_ex.rs2);
  assign op_a     = fwd_mux(sel_a, id_ex.rs1_data);
  assign op_b_reg = fwd_mux(sel_b, id_ex.rs2_data);
  assign op_b     = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_out = op_a - op_b;
      ALU_AND: alu_out = op_a & op_b;
      ALU_OR:  alu_out = op_a | op_b;
      ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_out = op_a + op_b;
    endcase
  end

  // beq / bne compare the raw register operands
  assign taken = id_ex.ctrl.branch &&
                 (id_ex.ctrl.branch_ne ? (op_a != op_b_reg) : (op_a == op_b_reg));

  assign redirect_valid  = id_ex.valid && (taken || id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr);
  assign redirect_target = id_ex.ctrl.is_jalr ? {alu_out[`XLEN-1:1], 1'b0}
                                              : id_ex.pc + id_ex.imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_res.valid <= 1'b0;
      ex_res.ctrl  <= '0;
    end else if (!stall_all) begin
      ex_res.valid <= id_ex.valid;
      ex_res.ctrl  <= id_ex.ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_all) begin
      ex_res.alu_out    <= alu_out;   // also the bus address
      ex_res.store_data <= op_b_reg;
      ex_res.link       <= id_ex.pc_plus_4;
      ex_res.rd         <= id_ex.rd;
    end
  end

endmodule

// ==== hdl/result_stage.sv ====
// ***************************************
// result stage
// wishbone classic master for lw / sw,
// writeback select and halt flag
// ***************************************
`include "core_macros.svh"

module result_stage import pipe_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  ex_res_if.sink           ex_res,
  wb_if.source             wb,
  output logic             stall_all,
  output logic             halted,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output logic [`XLEN-1:0] wb_adr,
  output logic [`XLEN-1:0] wb_dat_w,
  input  logic [`XLEN-1:0] wb_dat_r,
  input  logic             wb_ack
);
  typedef enum logic {
    S_IDLE,  // bus cycle runs here while a mem op waits
    S_DONE   // acked, writeback cycle
  } state_e;

  state_e           state;
  logic             mem_op;
  logic [`XLEN-1:0] load_data;

  assign mem_op = ex_res.valid && (ex_res.ctrl.mem_read || ex_res.ctrl.mem_write);

  // cyc rises with the op in ex/result, drops the cycle after ack
  assign wb_cyc   = mem_op && state == S_IDLE;
  assign wb_stb   = wb_cyc;
  assign wb_we    = wb_cyc && ex_res.ctrl.mem_write;
  assign wb_adr   = ex_res.alu_out;
  assign wb_dat_w = ex_res.store_data;

  assign stall_all   = mem_op && state != S_DONE;  // freeze until writeback cycle
  assign ex_res.busy = ex_res.valid && ex_res.ctrl.mem_read && state != S_DONE;

  always_comb begin
    if (ex_res.ctrl.mem_read)
      ex_res.fwd_value = load_data;
    else if (ex_res.ctrl.pc_to_reg)
      ex_res.fwd_value = ex_res.link;  // jal / jalr
    else
      ex_res.fwd_value = ex_res.alu_out;
  end

  always_ff @(posedge clk) begin
    if (reset)
      state <= S_IDLE;
    else if (state == S_IDLE && wb_cyc && wb_ack)
      state <= S_DONE;
    else if (state == S_DONE)
      state <= S_IDLE;  // op leaves ex/result on this edge
  end

  always_ff @(posedge clk) begin
    if (wb_cyc && wb_ack)
      load_data <= wb_dat_r;  // sampled with ack
  end

  // writeback register, holds during a stall so forwarding stays valid
  always_ff @(posedge clk) begin
    if (reset) begin
      wb.we  <= 1'b0;
      halted <= 1'b0;
    end else if (!stall_all) begin
      wb.we <= ex_res.valid && ex_res.ctrl.reg_write;
      if (ex_res.valid && ex_res.ctrl.is_halt)
        halted <= 1'b1;  // sticky till reset
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_all) begin
      wb.rd   <= ex_res.rd;
      wb.data <= ex_res.fwd_value;
    end
  end

endmodule

// ==== hdl/rv_core_top.sv ====
// ***************************************
// rv32i subset core top level
// three stages, wishbone data port,
// combinational instruction port
// ***************************************
`include "core_macros.svh"

module rv_core_top (
  input  logic             clk,
  input  logic             reset,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output logic [`XLEN-1:0] wb_adr,
  output logic [`XLEN-1:0] wb_dat_w,
  input  logic [`XLEN-1:0] wb_dat_r,
  input  logic             wb_ack,
  output logic             halted
);
  logic             stall_all;
  logic             redirect_valid;
  logic [`XLEN-1:0] redirect_target;

  id_ex_if  id_ex ();
  ex_res_if ex_res ();
  wb_if     wb ();

  decode_stage u_decode (
    .clk             (clk),
    .reset           (reset),
    .imem_addr       (imem_addr),
    .imem_data       (imem_data),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target),
    .stall_all       (stall_all),
    .halted          (halted),
    .id_ex           (id_ex.source),
    .wb              (wb.sink),
    .fwd_alu         (ex_res.fwd_value)  // ecall x17 bypass
  );

  execute_stage u_execute (
    .clk             (clk),
    .reset           (reset),
    .id_ex           (id_ex.sink),
    .ex_res          (ex_res.source),
    .wb              (wb.sink),
    .stall_all       (stall_all),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target)
  );

  result_stage u_result (
    .clk       (clk),
    .reset     (reset),
    .ex_res    (ex_res.sink),
    .wb        (wb.source),
    .stall_all (stall_all),
    .halted    (halted),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack)
  );

endmodule

// ==== tb/core_assertions.sv ====
// ****************************************
// bound checks on the core ports
// wishbone classic rules, reset state,
// halt behavior and skipped stores
// ****************************************
`include "core_macros.svh"

module core_assertions #(
  parameter logic [`XLEN-1:0] POISON_ADR = 32'h0000_00fc  // target of skipped stores
) (
  input logic             clk,
  input logic             reset,
  input logic [`XLEN-1:0] imem_addr,
  input logic             wb_cyc,
  input logic             wb_stb,
  input logic             wb_we,
  input logic [`XLEN-1:0] wb_adr,
  input logic [`XLEN-1:0] wb_dat_w,
  input logic             wb_ack,
  input logic             halted
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;  // polled by the testbench

  // one cycle into reset everything is idle, fetch at the reset vector
  reset_idle: assert property (@(posedge clk)
    reset |=> !wb_cyc && !wb_stb && !wb_we && !halted && imem_addr == `RESET_PC)
    else begin
      $error("bus, halt flag or pc not at reset value");
      fail_count++;
    end

  stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
    wb_stb |-> wb_cyc)
    else begin
      $error("stb high without cyc");
      fail_count++;
    end

  // waiting master holds the request
  hold_until_ack: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
    else begin
      $error("request changed before ack");
      fail_count++;
    end

  cyc_drops_after_ack: assert property (@(posedge clk) disable iff (reset)
    wb_cyc && wb_ack |=> !wb_cyc)
    else begin
      $error("cyc still high after ack");
      fail_count++;
    end

  // code behind a taken branch or jump never stores
  no_poison_store: assert property (@(posedge clk) disable iff (reset)
    wb_cyc && wb_we |-> wb_adr != POISON_ADR)
    else begin
      $error("store to an address of skipped code");
      fail_count++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
    else begin
      $error("halted dropped without reset");
      fail_count++;
    end

  halt_no_cyc: assert property (@(posedge clk) disable iff (reset)
    halted |-> !wb_cyc)
    else begin
      $error("bus cycle after halt");
      fail_count++;
    end

  halt_fetch_stops: assert property (@(posedge clk) disable iff (reset)
    halted |=> $stable(imem_addr))
    else begin
      $error("fetch moved after halt");
      fail_count++;
    end

endmodule

// ==== tb/core_tb.sv ====
// ****************************************
// testbench for the rv32i subset core
// program rom, wishbone memory with random
// wait states, expected store list
// ****************************************
`include "core_macros.svh"

module core_tb import isa_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          POISON_ADR = 'hfc;            // only skipped code stores here
  localparam logic [31:0] NOP        = 32'h0000_0013;   // addi x0, x0, 0

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r = '0;
  logic        wb_ack   = 1'b0;
  logic        halted;

  logic [31:0] rom [64];
  int          prog_len  = 0;
  logic        prog_ready = 1'b0;
  logic [31:0] shadow [32];    // register values by the isa rules
  logic [31:0] dmem [64];
  logic [31:0] exp_adr [$];
  logic [31:0] exp_val [$];
  string       exp_name [$];
  int          store_idx = 0;  // next expected store
  int          wait_left = -1; // -1 while no transfer is open

  rv_core_top uut (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .halted    (halted)
  );

  bind rv_core_top core_assertions #(.POISON_ADR(32'h0000_00fc)) u_chk (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_ack    (wb_ack),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // combinational rom, nops past the program
  assign imem_data = (imem_addr < 32'(4 * prog_len)) ? rom[imem_addr[7:2]] : NOP;

  function automatic logic [31:0] fill_word(input int i);
    return 32'h5a00_0000 + 32'(i) * 32'h0001_0103;  // differs in every index bit
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    inst_u w;
    w.r = '{f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_R};
    return w;
  endfunction

  function automatic logic [31:0] i_type(input opcode_e op, input int rd,
                                         input logic [2:0] f3, input int rs1, input int imm);
    inst_u w;
    w.i = '{imm[11:0], rs1[4:0], f3, rd[4:0], op};
    return w;
  endfunction

  function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    inst_u w;
    w.s = '{imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OP_STORE};
    return w;
  endfunction

  // branch offset split over the word
  function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1,
                                         input int rs2, input int off);
    inst_u w;
    w.b = '{off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BRANCH};
    return w;
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int off);
    inst_u w;
    w.j = '{off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
    return w;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic append_word(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic add_immediate(input int rd, input int rs1, input int imm);
    append_word(i_type(OP_IMM, rd, F3_ADD_SUB, rs1, imm));
    if (rd != 0)
      shadow[rd] = shadow[rs1] + 32'(imm);
  endtask

  // sw rs2, ofs(x0) plus its expected bus write
  task automatic expect_store(input int rs2, input int ofs, input string name);
    append_word(s_type(rs2, 0, ofs));
    exp_adr.push_back(32'(ofs));
    exp_val.push_back(shadow[rs2]);
    exp_name.push_back(name);
  endtask

  task automatic poison_store();
    append_word(s_type(0, 0, POISON_ADR));  // must be skipped
  endtask

  task automatic build_program();
    for (int i = 0; i < 32; i++)
      shadow[i] = '0;
    // dependent chain, every op feeds the next
    add_immediate(1, 0, 12);
    add_immediate(2, 1, 5);
    append_word(r_type(F7_SUB, F3_ADD_SUB, 3, 2, 1));
    shadow[3] = shadow[2] - shadow[1];
    append_word(r_type(F7_BASE, F3_AND, 4, 3, 2));
    shadow[4] = shadow[3] & shadow[2];
    append_word(r_type(F7_BASE, F3_OR, 5, 4, 2));
    shadow[5] = shadow[4] | shadow[2];
    append_word(r_type(F7_BASE, F3_SLT, 6, 1, 2));
    shadow[6] = ($signed(shadow[1]) < $signed(shadow[2])) ? 32'd1 : 32'd0;
    add_immediate(7, 0, -3);
    append_word(r_type(F7_BASE, F3_SLT, 8, 7, 1));
    shadow[8] = ($signed(shadow[7]) < $signed(shadow[1])) ? 32'd1 : 32'd0;
    expect_store(8, 'h80, "slt_negative");  // store data forwarded
    expect_store(3, 'h84, "sub_chain");
    expect_store(4, 'h88, "and_chain");
    expect_store(5, 'h8c, "or_chain");
    expect_store(6, 'h90, "slt_chain");
    // load then a dependent add, one bubble
    append_word(i_type(OP_LOAD, 9, F3_WORD, 0, 'h40));
    shadow[9] = fill_word('h40 / 4);
    append_word(r_type(F7_BASE, F3_ADD_SUB, 11, 9, 1));
    shadow[11] = shadow[9] + shadow[1];
    expect_store(11, 'h94, "load_use_add");
    // branches over poison stores
    add_immediate(12, 0, 7);
    append_word(b_type(F3_BEQ, 12, 12, 8));  // taken
    poison_store();
    append_word(b_type(F3_BNE, 12, 0, 8));   // taken
    poison_store();
    append_word(b_type(F3_BEQ, 12, 0, 8));   // not taken, falls through
    add_immediate(13, 0, 33);
    expect_store(13, 'h98, "branch_not_taken");
    shadow[14] = 32'(prog_len * 4 + 4);      // link of the jal below
    append_word(j_type(14, 8));
    poison_store();
    expect_store(14, 'h9c, "jal_link");
    add_immediate(15, 0, (prog_len + 3) * 4);  // lands just past the poison
    shadow[16] = 32'(prog_len * 4 + 4);
    append_word(i_type(OP_JALR, 16, 3'b000, 15, 0));
    poison_store();
    expect_store(16, 'ha0, "jalr_link");
    // ecall without the halt code
    add_immediate(17, 0, 3);
    append_word(i_type(OP_SYSTEM, 0, 3'b000, 0, 0));
    add_immediate(18, 0, 77);
    expect_store(18, 'ha4, "after_ecall");
    add_immediate(17, 0, `HALT_CODE);
    append_word(i_type(OP_SYSTEM, 0, 3'b000, 0, 0));
    poison_store();                          // behind the halt
  endtask

  task automatic check_store(input logic [31:0] adr, input logic [31:0] val);
    if (store_idx >= exp_adr.size())
      fail_now($sformatf("store of %h to %h after the last expected store", val, adr));
    else if (adr != exp_adr[store_idx])
      fail_now($sformatf("store went to %h but the next expected store is to %h",
                         adr, exp_adr[store_idx]));
    else if (val !== exp_val[store_idx])
      fail_now($sformatf("FAILED %s expected %h actual %h",
                         exp_name[store_idx], exp_val[store_idx], val));
    else
      store_idx++;
  endtask

  // wishbone slave, 0 to 3 wait states per transfer
  always @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < 64; i++)
        dmem[i] = fill_word(i);
      wb_ack    = 1'b0;
      wait_left = -1;
    end else if (wb_ack) begin
      wb_ack    = 1'b0;  // single-cycle ack
      wait_left = -1;
    end else if (wb_cyc && wb_stb) begin
      if (wait_left < 0)
        wait_left = int'($urandom % 4);
      if (wb_adr[31:8] != '0)
        fail_now($sformatf("bus access at %h is outside the data memory", wb_adr));
      else if (wait_left > 0)
        wait_left--;
      else begin
        wb_ack   = 1'b1;
        wb_dat_r = dmem[wb_adr[7:2]];
        if (wb_we) begin
          check_store(wb_adr, wb_dat_w);
          dmem[wb_adr[7:2]] = wb_dat_w;
        end
      end
    end
  end

  always @(negedge clk)
    if (uut.u_chk.fail_count != 0)
      fail_now("a bound assertion on the core failed");

  // watchdog scaled by program length
  initial begin
    wait (prog_ready);
    repeat (prog_len * 20) @(posedge clk);
    fail_now($sformatf("timeout, core did not halt within %0d cycles", prog_len * 20));
  end

  initial begin
    void'($urandom(32'hbb8e));  // one seed for the run
    reset = 1'b1;
    build_program();
    prog_ready = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    wait (halted);
    repeat (10) @(negedge clk);  // room for stray bus cycles
    if (store_idx != exp_adr.size())
      fail_now($sformatf("halted after %0d of %0d expected stores",
                         store_idx, exp_adr.size()));
    else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/pipe_ifs.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/rv_core_top.sv
tb/core_assertions.sv
tb/core_tb.sv

// ==== Makefile ====
# verilator build and run of the core testbench
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module core_tb -Mdir obj_dir -o core_sim -f flist.f

run: compile
	./obj_dir/core_sim +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
